//--- include/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Raster geometry, one clock per pixel
`define CNT_W       9
`define H_TOTAL     400
`define H_ACTIVE    320
`define V_TOTAL     262
`define V_ACTIVE    224

// Sync windows, start inclusive and end exclusive
`define HS_START    336
`define HS_END      368
`define VS_START    240
`define VS_END      243

// Pipeline delays
`define LAYER_DLY   16
`define MIX_DLY     2

// Memory port widths
`define MAP_AW      12
`define GFX_AW      15
`define PAL_AW      10

// Register map
`define REG_SCR1_H  3'd0
`define REG_SCR1_V  3'd1
`define REG_SCR2_H  3'd2
`define REG_SCR2_V  3'd3
`define REG_CTRL    3'd4

`endif

//--- source/video_pkg.sv
package video_pkg;

    // CPU register word, read as a scroll position or as the control bits
    typedef union packed {
        struct packed {
            logic [6:0]  unused;
            logic [8:0]  value;
        } pos;
        struct packed {
            logic [11:0] unused;
            logic        layer2_en;
            logic        layer1_en;
            logic        top_sel;
            logic        flip;
        } ctrl;
    } reg_word_t;

    // One layer pixel, pen 0 is transparent
    typedef struct packed {
        logic       prio;
        logic [5:0] bank;
        logic [3:0] pen;
    } layer_pxl_t;

endpackage

//--- source/layer_if.sv
`timescale 1ns/100ps
`include "video_consts.svh"

interface layer_if import video_pkg::*; ();

    // Control from the register block
    logic [`CNT_W-1:0] hscr;
    logic [`CNT_W-1:0] vscr;
    logic              enable;
    logic              flip;

    // Layer output towards the mixer
    layer_pxl_t        pxl;

    modport regs  (output hscr, output vscr, output enable, output flip);

    modport layer (input hscr, input vscr, input enable, input flip,
                   output pxl);

    modport mixer (input pxl);

endinterface

//--- source/video_timer.sv
`timescale 1ns/100ps
`include "video_consts.svh"

module video_timer (
    input  logic              clk,
    input  logic              reset,
    output logic [`CNT_W-1:0] hdump,
    output logic [`CNT_W-1:0] vdump,
    output logic              hblank,
    output logic              vblank,
    output logic              hs,
    output logic              vs,
    output logic              vint
);

    logic line_end;

    assign line_end = hdump == `H_TOTAL - 1;

    // Horizontal counter wraps every line, vertical one steps at the wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            hdump <= '0;
            vdump <= '0;
        end else if (line_end) begin
            hdump <= '0;
            if (vdump == `V_TOTAL - 1) begin
                vdump <= '0;
            end else begin
                vdump <= vdump + 1'b1;
            end
        end else begin
            hdump <= hdump + 1'b1;
        end
    end

    // Windows decoded straight from the counters
    assign hblank = hdump >= `H_ACTIVE;
    assign vblank = vdump >= `V_ACTIVE;
    assign hs     = hdump >= `HS_START && hdump < `HS_END;
    assign vs     = vdump >= `VS_START && vdump < `VS_END;

    // First pixel of the first blank line
    assign vint   = vdump == `V_ACTIVE && hdump == 0;

    a_hdump_range: assert property (
        @(posedge clk) disable iff (reset)
        hdump < `H_TOTAL
    ) else $error("hdump out of range: %0d", hdump);

endmodule

//--- source/video_regs.sv
`timescale 1ns/100ps
`include "video_consts.svh"

module video_regs import video_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       reg_we,
    input  logic [2:0] reg_addr,
    input  reg_word_t  reg_data,
    output logic       top_sel,
    layer_if.regs      lay1,
    layer_if.regs      lay2
);

    logic flip;

    // Flip is a board-wide setting
    assign lay1.flip = flip;
    assign lay2.flip = flip;

    always_ff @(posedge clk) begin
        if (reset) begin
            lay1.hscr   <= '0;
            lay1.vscr   <= '0;
            lay2.hscr   <= '0;
            lay2.vscr   <= '0;
            lay1.enable <= 1'b1;
            lay2.enable <= 1'b1;
            top_sel     <= 1'b0;
            flip        <= 1'b0;
        end else if (reg_we) begin
            case (reg_addr)
                `REG_SCR1_H: lay1.hscr <= reg_data.pos.value;
                `REG_SCR1_V: lay1.vscr <= reg_data.pos.value;
                `REG_SCR2_H: lay2.hscr <= reg_data.pos.value;
                `REG_SCR2_V: lay2.vscr <= reg_data.pos.value;
                `REG_CTRL: begin
                    flip        <= reg_data.ctrl.flip;
                    top_sel     <= reg_data.ctrl.top_sel;
                    lay1.enable <= reg_data.ctrl.layer1_en;
                    lay2.enable <= reg_data.ctrl.layer2_en;
                end
                default: begin
                end
            endcase
        end
    end

    // Only five registers are decoded
    a_reg_addr: assert property (
        @(posedge clk) disable iff (reset)
        reg_we |-> reg_addr <= `REG_CTRL
    ) else $error("write to unmapped register %0d", reg_addr);

endmodule

//--- source/tile_layer.sv
`timescale 1ns/100ps
`include "video_consts.svh"

module tile_layer import video_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [`CNT_W-1:0]  hdump,
    input  logic [`CNT_W-1:0]  vdump,
    output logic [`MAP_AW-1:0] map_addr,
    input  logic [15:0]        map_data,
    input  logic               map_ok,
    output logic [`GFX_AW-1:0] gfx_addr,
    input  logic [31:0]        gfx_data,
    input  logic               gfx_ok,
    layer_if.layer             lay
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_MAP  = 2'd1;
    localparam logic [1:0] ST_GFX  = 2'd2;

    logic [1:0]        state;
    logic [`CNT_W-1:0] out_col, mir_col, mir_row, scr_col, scr_row, fetch_col;
    logic              bnd;
    logic              map_prio, cur_prio, nxt_prio;
    logic [5:0]        map_bank, cur_bank, nxt_bank;
    logic [31:0]       gfx_row, cur_row, nxt_row;
    logic              gfx_valid;
    logic [3:0]        nxt_pen;

    // Column that enters the pixel register at the next edge
    assign out_col = hdump - 9'(`LAYER_DLY - 1);

    // Flip mirrors the screen, scroll moves it over the 512x512 map
    assign mir_col = lay.flip ? 9'(`H_ACTIVE - 1) - out_col : out_col;
    assign mir_row = lay.flip ? 9'(`V_ACTIVE - 1) - vdump : vdump;
    assign scr_col = mir_col + lay.hscr;
    assign scr_row = mir_row + lay.vscr;

    // First pixel of a tile in output order, flip walks the map backwards
    assign bnd       = scr_col[2:0] == (lay.flip ? 3'd7 : 3'd0);
    assign fetch_col = lay.flip ? scr_col - 9'd8 : scr_col + 9'd8;

    // A new group restarts the fetch, an unfinished one is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            gfx_valid <= 1'b0;
            map_addr  <= '0;
            gfx_addr  <= '0;
        end else if (bnd) begin
            state     <= ST_MAP;
            gfx_valid <= 1'b0;
            map_addr  <= {scr_row[8:3], fetch_col[8:3]};
        end else begin
            case (state)
                ST_MAP: if (map_ok) begin
                    state    <= ST_GFX;
                    // One 32-bit word per tile row, word index fixed at 0
                    gfx_addr <= {map_data[8:0], scr_row[2:0], 3'd0};
                end
                ST_GFX: if (gfx_ok) begin
                    state     <= ST_IDLE;
                    gfx_valid <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_MAP && map_ok) begin
            map_prio <= map_data[15];
            map_bank <= map_data[14:9];
        end
        if (state == ST_GFX && gfx_ok) begin
            gfx_row <= gfx_data;
        end
    end

    // Late data leaves the whole group transparent
    always_comb begin
        nxt_row  = bnd ? (gfx_valid ? gfx_row : 32'd0) : cur_row;
        nxt_prio = bnd ? (gfx_valid & map_prio) : cur_prio;
        nxt_bank = bnd ? (gfx_valid ? map_bank : 6'd0) : cur_bank;
        nxt_pen  = lay.flip ? nxt_row[3:0] : nxt_row[31:28];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_row  <= '0;
            cur_prio <= 1'b0;
            cur_bank <= '0;
            lay.pxl  <= '0;
        end else begin
            cur_row  <= lay.flip ? nxt_row >> 4 : nxt_row << 4;
            cur_prio <= nxt_prio;
            cur_bank <= nxt_bank;
            if (lay.enable) begin
                lay.pxl <= '{prio: nxt_prio, bank: nxt_bank, pen: nxt_pen};
            end else begin
                lay.pxl <= '0;
            end
        end
    end

    a_map_hold: assert property (
        @(posedge clk) disable iff (reset)
        state == ST_MAP && !map_ok && !bnd |=> $stable(map_addr)
    ) else $error("map_addr changed while its request was pending");

endmodule

//--- source/color_mixer.sv
`timescale 1ns/100ps
`include "video_consts.svh"

module color_mixer import video_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               hblank,
    input  logic               vblank,
    input  logic               top_sel,
    layer_if.mixer             lay1,
    layer_if.mixer             lay2,
    input  logic               pal_we,
    input  logic [`PAL_AW-1:0] pal_addr,
    input  logic [14:0]        pal_data,
    output logic [4:0]         red,
    output logic [4:0]         green,
    output logic [4:0]         blue,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);

    // Blanking also covers the layer latency so it lines up with the pixels
    localparam int BLK_DLY = `LAYER_DLY + `MIX_DLY;

    logic [14:0]        pal_ram [0:(1 << `PAL_AW) - 1];
    layer_pxl_t         top_pxl, bot_pxl, win_pxl;
    logic [`PAL_AW-1:0] pal_idx, pal_idx_r;
    logic [BLK_DLY-1:0] hb_sr, vb_sr;
    logic               blank_next;

    always_comb begin
        top_pxl = top_sel ? lay2.pxl : lay1.pxl;
        bot_pxl = top_sel ? lay1.pxl : lay2.pxl;
        // Opaque priority pixel beats an ordinary one on either layer
        if (bot_pxl.pen != 4'd0 && bot_pxl.prio && !(top_pxl.pen != 4'd0 && top_pxl.prio)) begin
            win_pxl = bot_pxl;
        end else if (top_pxl.pen != 4'd0) begin
            win_pxl = top_pxl;
        end else begin
            win_pxl = bot_pxl;
        end
        pal_idx = win_pxl.pen == 4'd0 ? '0 : {win_pxl.bank, win_pxl.pen};
    end

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_data;
        end
    end

    // Blank state that reaches the outputs at this edge
    assign blank_next = hb_sr[BLK_DLY-2] | vb_sr[BLK_DLY-2];

    // Palette word is red in the top five bits, blue in the bottom five
    always_ff @(posedge clk) begin
        if (reset) begin
            pal_idx_r <= '0;
            hb_sr     <= '1;
            vb_sr     <= '1;
            {red, green, blue} <= '0;
        end else begin
            pal_idx_r <= pal_idx;
            hb_sr     <= {hb_sr[BLK_DLY-2:0], hblank};
            vb_sr     <= {vb_sr[BLK_DLY-2:0], vblank};
            if (blank_next) begin
                {red, green, blue} <= '0;
            end else begin
                {red, green, blue} <= pal_ram[pal_idx_r];
            end
        end
    end

    // High while the delayed picture is visible
    assign lhbl_dly = ~hb_sr[BLK_DLY-1];
    assign lvbl_dly = ~vb_sr[BLK_DLY-1];

endmodule

//--- source/video_top.sv
`timescale 1ns/100ps
`include "video_consts.svh"

module video_top (
    input  logic               clk,
    input  logic               reset,
    // CPU register and palette writes
    input  logic               reg_we,
    input  logic [2:0]         reg_addr,
    input  logic [15:0]        reg_data,
    input  logic               pal_we,
    input  logic [`PAL_AW-1:0] pal_addr,
    input  logic [14:0]        pal_data,
    // Layer 1 memory
    output logic [`MAP_AW-1:0] map1_addr,
    input  logic [15:0]        map1_data,
    input  logic               map1_ok,
    output logic [`GFX_AW-1:0] gfx1_addr,
    input  logic [31:0]        gfx1_data,
    input  logic               gfx1_ok,
    // Layer 2 memory
    output logic [`MAP_AW-1:0] map2_addr,
    input  logic [15:0]        map2_data,
    input  logic               map2_ok,
    output logic [`GFX_AW-1:0] gfx2_addr,
    input  logic [31:0]        gfx2_data,
    input  logic               gfx2_ok,
    // Video timing and colour
    output logic [`CNT_W-1:0]  hdump,
    output logic [`CNT_W-1:0]  vdump,
    output logic               hblank,
    output logic               vblank,
    output logic               hs,
    output logic               vs,
    output logic               vint,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output logic [4:0]         red,
    output logic [4:0]         green,
    output logic [4:0]         blue
);

    logic top_sel;

    layer_if u_lay1_if ();
    layer_if u_lay2_if ();

    video_timer u_timer (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .hdump  ( hdump  ),
        .vdump  ( vdump  ),
        .hblank ( hblank ),
        .vblank ( vblank ),
        .hs     ( hs     ),
        .vs     ( vs     ),
        .vint   ( vint   )
    );

    video_regs u_regs (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .reg_we   ( reg_we    ),
        .reg_addr ( reg_addr  ),
        .reg_data ( reg_data  ),
        .top_sel  ( top_sel   ),
        .lay1     ( u_lay1_if ),
        .lay2     ( u_lay2_if )
    );

    tile_layer u_layer1 (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .map_addr ( map1_addr ),
        .map_data ( map1_data ),
        .map_ok   ( map1_ok   ),
        .gfx_addr ( gfx1_addr ),
        .gfx_data ( gfx1_data ),
        .gfx_ok   ( gfx1_ok   ),
        .lay      ( u_lay1_if )
    );

    tile_layer u_layer2 (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .map_addr ( map2_addr ),
        .map_data ( map2_data ),
        .map_ok   ( map2_ok   ),
        .gfx_addr ( gfx2_addr ),
        .gfx_data ( gfx2_data ),
        .gfx_ok   ( gfx2_ok   ),
        .lay      ( u_lay2_if )
    );

    color_mixer u_mixer (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .hblank   ( hblank    ),
        .vblank   ( vblank    ),
        .top_sel  ( top_sel   ),
        .lay1     ( u_lay1_if ),
        .lay2     ( u_lay2_if ),
        .pal_we   ( pal_we    ),
        .pal_addr ( pal_addr  ),
        .pal_data ( pal_data  ),
        .red      ( red       ),
        .green    ( green     ),
        .blue     ( blue      ),
        .lhbl_dly ( lhbl_dly  ),
        .lvbl_dly ( lvbl_dly  )
    );

endmodule

//--- tb/video_tb.sv
`timescale 1ns/100ps
`include "video_consts.svh"

module video_tb import video_pkg::*; ();

    localparam int FRAME   = `H_TOTAL * `V_TOTAL;
    localparam int PIX_DLY = `LAYER_DLY + `MIX_DLY;

    logic               clk;
    logic               reset;
    logic               reg_we;
    logic [2:0]         reg_addr;
    reg_word_t          reg_data;
    logic               pal_we;
    logic [`PAL_AW-1:0] pal_addr;
    logic [14:0]        pal_data;
    logic [`MAP_AW-1:0] map1_addr, map2_addr;
    logic [15:0]        map1_data, map2_data;
    logic               map1_ok, map2_ok;
    logic [`GFX_AW-1:0] gfx1_addr, gfx2_addr;
    logic [31:0]        gfx1_data, gfx2_data;
    logic               gfx1_ok, gfx2_ok;
    logic [`CNT_W-1:0]  hdump, vdump;
    logic               hblank, vblank, hs, vs, vint, lhbl_dly, lvbl_dly;
    logic [4:0]         red, green, blue;

    // Reference model state
    logic [31:0]        gfx_mem [0:4095];
    logic [14:0]        pal_model [0:1023];
    logic [8:0]         hscr [0:1];
    logic [8:0]         vscr [0:1];
    logic               en [0:1];
    logic               flip;
    logic               top_sel;
    logic [11:0]        last_map [0:1];
    logic [14:0]        last_gfx [0:1];
    int                 kill_grp;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;

    video_top UUT (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .reg_we    ( reg_we    ),
        .reg_addr  ( reg_addr  ),
        .reg_data  ( reg_data  ),
        .pal_we    ( pal_we    ),
        .pal_addr  ( pal_addr  ),
        .pal_data  ( pal_data  ),
        .map1_addr ( map1_addr ),
        .map1_data ( map1_data ),
        .map1_ok   ( map1_ok   ),
        .gfx1_addr ( gfx1_addr ),
        .gfx1_data ( gfx1_data ),
        .gfx1_ok   ( gfx1_ok   ),
        .map2_addr ( map2_addr ),
        .map2_data ( map2_data ),
        .map2_ok   ( map2_ok   ),
        .gfx2_addr ( gfx2_addr ),
        .gfx2_data ( gfx2_data ),
        .gfx2_ok   ( gfx2_ok   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .hblank    ( hblank    ),
        .vblank    ( vblank    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .vint      ( vint      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Map word that depends on every address bit and is permuted for layer 2
    function automatic logic [15:0] map_word(input int lyr, input logic [11:0] a);
        logic [11:0] b;
        b = a ^ (lyr != 0 ? 12'h5a3 : 12'h000);
        return {b[3] ^ b[7], b[5:0] ^ b[11:6], b[8:0] ^ {b[11:9], b[11:6]}};
    endfunction

    function automatic logic [14:0] pal_color(input int i, input int k);
        return 15'(i * (k != 0 ? 97 : 37) + (k != 0 ? 11 : 5));
    endfunction

    // Layer pixel for screen column h of line v
    function automatic layer_pxl_t predict_pxl(input int lyr, input int v, input int h);
        logic [8:0]  mc, mr, sc, sr;
        logic [15:0] mw;
        logic [31:0] gw;
        layer_pxl_t  p;
        if (!en[lyr] || (lyr == 0 && kill_grp >= 0 && h / 8 == kill_grp)) begin
            return '0;
        end
        mc = flip ? 9'(`H_ACTIVE - 1 - h) : 9'(h);
        mr = flip ? 9'(`V_ACTIVE - 1 - v) : 9'(v);
        sc = mc + hscr[lyr];
        sr = mr + vscr[lyr];
        mw = map_word(lyr, {sr[8:3], sc[8:3]});
        gw = gfx_mem[{mw[8:0], sr[2:0]}];
        p.prio = mw[15];
        p.bank = mw[14:9];
        p.pen  = 4'(gw >> (28 - 4 * int'(sc[2:0])));
        return p;
    endfunction

    // Opaque pixels rank by priority bit and then by top_sel
    function automatic logic [9:0] mix_index(input layer_pxl_t p1, input layer_pxl_t p2);
        int         r1, r2;
        layer_pxl_t w;
        r1 = p1.pen == 0 ? -1 : 2 * p1.prio + (top_sel ? 0 : 1);
        r2 = p2.pen == 0 ? -1 : 2 * p2.prio + (top_sel ? 1 : 0);
        if (r1 < 0 && r2 < 0) begin
            return 10'd0;
        end
        w = r1 > r2 ? p1 : p2;
        return {w.bank, w.pen};
    endfunction

    function automatic logic late_window(input logic [8:0] h);
        return kill_grp >= 0 && h >= 8 * kill_grp + 8 && h <= 8 * kill_grp + 15;
    endfunction

    // Memories answer one cycle after an address change
    always @(negedge clk) begin
        map1_data   <= map_word(0, map1_addr);
        map2_data   <= map_word(1, map2_addr);
        map1_ok     <= map1_addr == last_map[0];
        map2_ok     <= map2_addr == last_map[1];
        last_map[0] <= map1_addr;
        last_map[1] <= map2_addr;
        gfx1_data   <= gfx_mem[gfx1_addr[14:3]];
        gfx2_data   <= gfx_mem[gfx2_addr[14:3]];
        gfx1_ok     <= gfx1_addr == last_gfx[0] && !late_window(hdump);
        gfx2_ok     <= gfx2_addr == last_gfx[1];
        last_gfx[0] <= gfx1_addr;
        last_gfx[1] <= gfx2_addr;
    end

    task automatic check_rgb(input logic [4:0] er, eg, eb, input logic [4:0] gr, gg, gb,
                             input string what);
        if ({gr, gg, gb} !== {er, eg, eb}) begin
            errors++;
            $display("ERROR at %0t: %s rgb %0d,%0d,%0d expected %0d,%0d,%0d",
                     $time, what, gr, gg, gb, er, eg, eb);
        end
    endtask

    task automatic check_pxl(input layer_pxl_t exp, input layer_pxl_t got, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s pixel %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cnt(input logic [8:0] exp, input logic [8:0] got, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        tests_run++;
        if (errors == start_errs) begin
            $display("%-16s ok", name);
        end else begin
            tests_failed++;
            $display("%-16s FAILED with %0d errors", name, errors - start_errs);
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input reg_word_t w);
        @(negedge clk);
        reg_we   = 1'b1;
        reg_addr = addr;
        reg_data = w;
        @(negedge clk);
        reg_we   = 1'b0;
    endtask

    task automatic set_scroll(input int lyr, input logic [8:0] h, input logic [8:0] v);
        reg_word_t w;
        w = '0;
        w.pos.value = h;
        write_reg(lyr != 0 ? `REG_SCR2_H : `REG_SCR1_H, w);
        w.pos.value = v;
        write_reg(lyr != 0 ? `REG_SCR2_V : `REG_SCR1_V, w);
        hscr[lyr] = h;
        vscr[lyr] = v;
    endtask

    task automatic set_ctrl(input logic e1, input logic e2, input logic ts, input logic fl);
        reg_word_t w;
        w = '0;
        w.ctrl.layer1_en = e1;
        w.ctrl.layer2_en = e2;
        w.ctrl.top_sel   = ts;
        w.ctrl.flip      = fl;
        write_reg(`REG_CTRL, w);
        en[0]   = e1;
        en[1]   = e2;
        top_sel = ts;
        flip    = fl;
    endtask

    task automatic load_palette(input int k);
        for (int i = 0; i < 1024; i++) begin
            @(negedge clk);
            pal_we       = 1'b1;
            pal_addr     = 10'(i);
            pal_data     = pal_color(i, k);
            pal_model[i] = pal_color(i, k);
        end
        @(negedge clk);
        pal_we = 1'b0;
    endtask

    // Compares layer outputs and RGB with the model over one full line from hdump 0
    task automatic sample_line(input string what);
        int         v;
        logic [14:0] c;
        while (hdump != 0) @(negedge clk);
        v = vdump;
        for (int t = 0; t < `H_TOTAL; t++) begin
            if (t >= `LAYER_DLY && t < `H_ACTIVE + `LAYER_DLY) begin
                check_pxl(predict_pxl(0, v, t - `LAYER_DLY), UUT.u_lay1_if.pxl, what);
                check_pxl(predict_pxl(1, v, t - `LAYER_DLY), UUT.u_lay2_if.pxl, what);
            end
            if (t >= PIX_DLY && t < `H_ACTIVE + PIX_DLY) begin
                c = pal_model[mix_index(predict_pxl(0, v, t - PIX_DLY),
                                        predict_pxl(1, v, t - PIX_DLY))];
            end else begin
                c = '0;
            end
            check_rgb(c[14:10], c[9:5], c[4:0], red, green, blue, what);
            @(negedge clk);
        end
    endtask

    // Starts on the falling edge where reset is released
    task automatic raster_timing();
        int   start, eh, ev, vints;
        logic hq[$];
        logic vq[$];
        start = errors;
        eh    = 0;
        ev    = 0;
        vints = 0;
        repeat (PIX_DLY) begin
            hq.push_back(1'b1);
            vq.push_back(1'b1);
        end
        repeat (FRAME) begin
            check_cnt(9'(eh), hdump, "hdump");
            check_cnt(9'(ev), vdump, "vdump");
            check_flag(eh >= `H_ACTIVE, hblank, "hblank");
            check_flag(ev >= `V_ACTIVE, vblank, "vblank");
            check_flag(eh >= `HS_START && eh < `HS_END, hs, "hs");
            check_flag(ev >= `VS_START && ev < `VS_END, vs, "vs");
            check_flag(ev == `V_ACTIVE && eh == 0, vint, "vint");
            check_flag(!hq[0], lhbl_dly, "lhbl_dly");
            check_flag(!vq[0], lvbl_dly, "lvbl_dly");
            if (vint) vints++;
            void'(hq.pop_front());
            void'(vq.pop_front());
            hq.push_back(eh >= `H_ACTIVE);
            vq.push_back(ev >= `V_ACTIVE);
            @(negedge clk);
            eh++;
            if (eh == `H_TOTAL) begin
                eh = 0;
                ev = ev == `V_TOTAL - 1 ? 0 : ev + 1;
            end
        end
        if (vints != 1) begin
            errors++;
            $display("Frame interrupt pulsed %0d times in one frame instead of once", vints);
        end
        report_test("raster timing", start);
    endtask

    task automatic single_layer();
        int start;
        start = errors;
        set_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
        repeat (3) sample_line("single layer");
        report_test("single layer", start);
    endtask

    task automatic scroll_and_flip();
        int start;
        start = errors;
        set_scroll(0, 9'd37, 9'd101);
        repeat (2) sample_line("scroll");
        set_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
        repeat (2) sample_line("flip");
        report_test("scroll and flip", start);
    endtask

    task automatic layer_priority();
        int start;
        start = errors;
        set_scroll(1, 9'd13, 9'd77);
        set_ctrl(1'b1, 1'b1, 1'b0, 1'b0);
        repeat (2) sample_line("priority top 1");
        set_ctrl(1'b1, 1'b1, 1'b1, 1'b0);
        repeat (2) sample_line("priority top 2");
        report_test("layer priority", start);
    endtask

    task automatic palette_update();
        int start;
        start = errors;
        load_palette(1);
        repeat (2) sample_line("palette");
        report_test("palette update", start);
    endtask

    // Group 5 loses its graphics ok so columns 40 to 47 go transparent
    task automatic late_gfx_ok();
        int start;
        start = errors;
        set_scroll(0, 9'd0, 9'd0);
        set_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
        kill_grp = 5;
        sample_line("late ok");
        sample_line("late ok");
        kill_grp = -1;
        report_test("late gfx ok", start);
    endtask

    initial begin
        logic [31:0] lfsr;
        logic [31:0] word;
        reset        = 1'b1;
        reg_we       = 1'b0;
        reg_addr     = '0;
        reg_data     = '0;
        pal_we       = 1'b0;
        pal_addr     = '0;
        pal_data     = '0;
        map1_data    = '0;
        map2_data    = '0;
        map1_ok      = 1'b0;
        map2_ok      = 1'b0;
        gfx1_data    = '0;
        gfx2_data    = '0;
        gfx1_ok      = 1'b0;
        gfx2_ok      = 1'b0;
        last_map     = '{default: '0};
        last_gfx     = '{default: '0};
        hscr         = '{default: '0};
        vscr         = '{default: '0};
        en           = '{default: 1'b1};
        flip         = 1'b0;
        top_sel      = 1'b0;
        kill_grp     = -1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        // Graphics words built with one LFSR step per bit
        lfsr = 32'hb19d_7228;
        word = '0;
        for (int i = 0; i < 4096; i++) begin
            for (int b = 0; b < 32; b++) begin
                word = {word[30:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
            gfx_mem[i] = word;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        raster_timing();
        load_palette(0);
        single_layer();
        scroll_and_flip();
        layer_priority();
        palette_update();
        late_gfx_ok();
        $display("Tests run: %0d, failing: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Three frames cover one frame of timing checks and a few dozen pixel lines
    initial begin
        #(3 * FRAME * 100);
        $display("Timeout: the tests did not finish within three frames");
        $display("Test failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/video_pkg.sv
source/layer_if.sv
source/video_timer.sv
source/video_regs.sv
source/tile_layer.sv
source/color_mixer.sv
source/video_top.sv
tb/video_tb.sv

//--- Bender.yml
package:
  name: video_tile

sources:
  - include_dirs:
      - include
    files:
      - source/video_pkg.sv
      - source/layer_if.sv
      - source/video_timer.sv
      - source/video_regs.sv
      - source/tile_layer.sv
      - source/color_mixer.sv
      - source/video_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/video_tb.sv
